/* exit_periph.sv */
`timescale 1ns/100ps

`include "mini_mcu_cfg.svh"

module exit_periph (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mini_mcu_pkg::apb_req_t   apb_req_i,
  output mini_mcu_pkg::apb_resp_t  apb_resp_o,
  output mini_mcu_pkg::word_t      exit_value_o,
  output logic                     exit_valid_o,
  output logic                     tests_passed_o,
  output logic                     tests_failed_o
);

  import mini_mcu_pkg::*;

  word_t exit_value_q;
  logic  exit_valid_q;
  logic  passed_q;
  logic  failed_q;
  logic  wr_en;
  word_t status_word;

  // no wait states, so every access phase is also the completing one
  assign wr_en       = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
  assign status_word = {30'b0, failed_q, passed_q};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      passed_q     <= 1'b0;
      failed_q     <= 1'b0;
    end else begin
      exit_valid_q <= wr_en && (apb_req_i.paddr == `MINI_MCU_EXIT_OFS);
      // verdict bits only ever get set
      if (wr_en && apb_req_i.paddr == `MINI_MCU_STATUS_OFS) begin
        passed_q <= passed_q | apb_req_i.pwdata[0];
        failed_q <= failed_q | apb_req_i.pwdata[1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && apb_req_i.paddr == `MINI_MCU_EXIT_OFS) exit_value_q <= apb_req_i.pwdata;
  end

  assign apb_resp_o = '{pready: apb_req_i.penable,
                        prdata: (apb_req_i.paddr == `MINI_MCU_EXIT_OFS) ? exit_value_q
                                                                         : status_word};

  assign exit_value_o   = exit_value_q;
  assign exit_valid_o   = exit_valid_q;
  assign tests_passed_o = passed_q;
  assign tests_failed_o = failed_q;

endmodule

/* mini_mcu.f */
+incdir+.
mini_mcu_pkg.sv
tiny_core.sv
mm_ram.sv
exit_periph.sv
mini_mcu.sv
mini_mcu_assertions.sv
tb_mini_mcu.sv

/* mini_mcu.sv */
`timescale 1ns/100ps

module mini_mcu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 fetch_enable_i,
  input  logic                 load_we_i,
  input  mini_mcu_pkg::addr_t  load_addr_i,
  input  mini_mcu_pkg::word_t  load_wdata_i,
  output logic                 tests_passed_o,
  output logic                 tests_failed_o,
  output logic                 exit_valid_o,
  output logic                 core_sleep_o,
  output mini_mcu_pkg::word_t  exit_value_o
);

  import mini_mcu_pkg::*;

  // core to memory controller
  bus_req_t  core_req;
  bus_resp_t core_resp;

  // memory controller to exit peripheral
  apb_req_t  periph_req;
  apb_resp_t periph_resp;

  tiny_core core0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .bus_resp_i     (core_resp),
    .bus_req_o      (core_req),
    .core_sleep_o   (core_sleep_o)
  );

  mm_ram ram0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .core_req_i    (core_req),
    .core_resp_o   (core_resp),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_wdata_i  (load_wdata_i),
    .periph_req_o  (periph_req),
    .periph_resp_i (periph_resp)
  );

  exit_periph periph0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .apb_req_i      (periph_req),
    .apb_resp_o     (periph_resp),
    .exit_value_o   (exit_value_o),
    .exit_valid_o   (exit_valid_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o)
  );

endmodule

/* mini_mcu_assertions.sv */
`timescale 1ns/100ps

module mini_mcu_assertions (
  input logic                     clk_i,
  input logic                     rst_i,
  input mini_mcu_pkg::bus_req_t   bus_req_i,
  input mini_mcu_pkg::bus_resp_t  bus_resp_i,
  input mini_mcu_pkg::apb_req_t   apb_req_i,
  input logic                     exit_valid_i
);

  // number of assertion failures so far
  int fail_count = 0;

  // a waiting request keeps every field until it is granted
  req_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (bus_req_i.req && !bus_resp_i.gnt) |=> (bus_req_i.req && $stable(bus_req_i)))
    else begin
      $error("core request changed before grant");
      fail_count++;
    end

  rvalid_after_gnt_a: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_resp_i.rvalid |-> $past(bus_resp_i.gnt))
    else begin
      $error("rvalid without a grant in the previous cycle");
      fail_count++;
    end

  // APB access phase is entered only from setup
  penable_after_setup_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(apb_req_i.penable) |-> $past(apb_req_i.psel && !apb_req_i.penable))
    else begin
      $error("penable rose without a setup cycle");
      fail_count++;
    end

  exit_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    exit_valid_i |=> !exit_valid_i)
    else begin
      $error("exit_valid_o high for two cycles");
      fail_count++;
    end

endmodule

// the nets at the top are the ports of mm_ram and exit_periph
bind mini_mcu mini_mcu_assertions chk0 (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .bus_req_i    (core_req),
  .bus_resp_i   (core_resp),
  .apb_req_i    (periph_req),
  .exit_valid_i (exit_valid_o)
);

/* mini_mcu_cfg.svh */
`ifndef MINI_MCU_CFG_SVH
`define MINI_MCU_CFG_SVH

// on-chip RAM depth in 32-bit words
`define MINI_MCU_RAM_WORDS 256

// word address width seen by the core
`define MINI_MCU_ADDR_W 16

// address map
// bits 15:12 pick the region: 0 is RAM, 2 is the exit peripheral,
// anything else is unmapped (reads 0, writes dropped)
`define MINI_MCU_PERIPH_BASE 16'h2000

// exit peripheral register offsets
`define MINI_MCU_EXIT_OFS 1'b0
`define MINI_MCU_STATUS_OFS 1'b1

`endif

/* mini_mcu_pkg.sv */
`include "mini_mcu_cfg.svh"

package mini_mcu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [`MINI_MCU_ADDR_W-1:0] addr_t;

  // instruction bits 31:28, operand in bits 15:0
  typedef enum logic [3:0] {
    HALT = 4'h0,
    LDI  = 4'h1,
    LD   = 4'h2,
    ST   = 4'h3,
    ADD  = 4'h4,
    SUB  = 4'h5,
    BNZ  = 4'h6,
    JMP  = 4'h7
  } opcode_e;

  // core side bus, request/grant with a separate response valid
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } bus_resp_t;

  // APB towards the exit peripheral, one offset bit is enough
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    logic  paddr;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
  } apb_resp_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_INSTR,
    EXECUTE,
    WAIT_DATA,
    SLEEP
  } core_state_e;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS
  } bridge_state_e;

endpackage

/* mm_ram.sv */
`timescale 1ns/100ps

`include "mini_mcu_cfg.svh"

module mm_ram (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mini_mcu_pkg::bus_req_t   core_req_i,
  output mini_mcu_pkg::bus_resp_t  core_resp_o,
  input  logic                     load_we_i,
  input  mini_mcu_pkg::addr_t      load_addr_i,
  input  mini_mcu_pkg::word_t      load_wdata_i,
  output mini_mcu_pkg::apb_req_t   periph_req_o,
  input  mini_mcu_pkg::apb_resp_t  periph_resp_i
);

  import mini_mcu_pkg::*;

  localparam int         AW            = `MINI_MCU_ADDR_W;
  localparam int         RAM_AW        = $clog2(`MINI_MCU_RAM_WORDS);
  localparam logic [3:0] PERIPH_REGION = 4'(`MINI_MCU_PERIPH_BASE >> (AW - 4));

  word_t             mem [`MINI_MCU_RAM_WORDS];
  bridge_state_e     br_state_q;
  logic [3:0]        region;
  logic              sel_ram;
  logic              sel_periph;
  logic [RAM_AW-1:0] core_idx;
  logic [RAM_AW-1:0] load_idx;
  logic              ram_gnt;
  logic              periph_gnt;
  logic              unmapped_gnt;
  logic              gnt;
  logic              rvalid_q;
  word_t             rdata_d;
  word_t             rdata_q;
  logic              paddr_q;
  logic              pwrite_q;
  word_t             pwdata_q;

  // region decode on the top address nibble
  assign region     = core_req_i.addr[AW-1 -: 4];
  assign sel_ram    = (region == 4'h0);
  assign sel_periph = (region == PERIPH_REGION);
  assign core_idx   = core_req_i.addr[RAM_AW-1:0];
  assign load_idx   = load_addr_i[RAM_AW-1:0];

  // load port owns the RAM in any cycle it writes
  assign ram_gnt      = core_req_i.req && sel_ram && !load_we_i;
  assign periph_gnt   = core_req_i.req && sel_periph &&
                        (br_state_q == BR_ACCESS) && periph_resp_i.pready;
  assign unmapped_gnt = core_req_i.req && !sel_ram && !sel_periph;
  assign gnt          = ram_gnt || periph_gnt || unmapped_gnt;

  // unmapped reads fall through to zero
  always_comb begin
    rdata_d = '0;
    if (ram_gnt) begin
      rdata_d = mem[core_idx];
    end else if (periph_gnt) begin
      rdata_d = periph_resp_i.prdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem[load_idx] <= load_wdata_i;
    end else if (ram_gnt && core_req_i.we) begin
      mem[core_idx] <= core_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) rdata_q <= rdata_d;
  end

  // one response per grant, for writes as well
  always_ff @(posedge clk_i) begin
    if (rst_i) rvalid_q <= 1'b0;
    else       rvalid_q <= gnt;
  end

  // APB master, the request is latched when leaving idle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      br_state_q <= BR_IDLE;
    end else begin
      case (br_state_q)
        BR_IDLE: begin
          if (core_req_i.req && sel_periph) br_state_q <= BR_SETUP;
        end
        BR_SETUP:  br_state_q <= BR_ACCESS;
        BR_ACCESS: begin
          if (periph_resp_i.pready) br_state_q <= BR_IDLE;
        end
        default:   br_state_q <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (br_state_q == BR_IDLE && core_req_i.req && sel_periph) begin
      paddr_q  <= core_req_i.addr[0];
      pwrite_q <= core_req_i.we;
      pwdata_q <= core_req_i.wdata;
    end
  end

  assign core_resp_o  = '{gnt: gnt, rvalid: rvalid_q, rdata: rdata_q};
  assign periph_req_o = '{psel:    (br_state_q != BR_IDLE),
                          penable: (br_state_q == BR_ACCESS),
                          pwrite:  pwrite_q,
                          paddr:   paddr_q,
                          pwdata:  pwdata_q};

endmodule

/* tb_mini_mcu.sv */
`timescale 1ns/100ps

`include "mini_mcu_cfg.svh"

module tb_mini_mcu;

  import mini_mcu_pkg::*;

  localparam int    RAM_WORDS     = `MINI_MCU_RAM_WORDS;
  localparam int    MAX_STEPS     = 300;
  localparam int    RUN_CYCLES    = 3000;
  localparam int    SETTLE_CYCLES = 40;
  // six programs of up to 300 instructions at 6 cycles, plus loads and margin
  localparam int    CYCLE_LIMIT   = 20000;
  localparam addr_t EXIT_ADDR     = `MINI_MCU_PERIPH_BASE | 16'(`MINI_MCU_EXIT_OFS);
  localparam addr_t STATUS_ADDR   = `MINI_MCU_PERIPH_BASE | 16'(`MINI_MCU_STATUS_OFS);
  localparam addr_t UNMAPPED_ADDR = 16'h5034;

  logic  clk_i;
  logic  rst_i;
  logic  fetch_enable_i;
  logic  load_we_i;
  addr_t load_addr_i;
  word_t load_wdata_i;
  logic  tests_passed_o;
  logic  tests_failed_o;
  logic  exit_valid_o;
  logic  core_sleep_o;
  word_t exit_value_o;

  word_t prog [RAM_WORDS];
  word_t model_mem [RAM_WORDS];
  word_t model_exits[$];
  word_t dut_exits[$];
  word_t model_exit_reg;
  logic  model_passed;
  logic  model_failed;
  int    errors;
  int    test_errors;
  int    assert_fails;
  int    tests_run;
  int    tests_bad;
  int    cycle_count;
  int    seed_val;

  mini_mcu dut0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .load_we_i      (load_we_i),
    .load_addr_i    (load_addr_i),
    .load_wdata_i   (load_wdata_i),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .core_sleep_o   (core_sleep_o),
    .exit_value_o   (exit_value_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("run stopped after %0d cycles, a test hung", CYCLE_LIMIT);
    $display("Testbench failed");
    $finish;
  end

  function automatic word_t encode_instr(logic [3:0] op, addr_t operand);
    return {op, 12'h000, operand};
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_quiet();
    if (exit_valid_o !== 1'b0 || tests_passed_o !== 1'b0 ||
        tests_failed_o !== 1'b0 || core_sleep_o !== 1'b0) begin
      $display("outputs became active at %0t while the core was disabled", $time);
      errors++;
    end
  endtask

  task automatic reset_dut();
    @(negedge clk_i);
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    load_we_i      = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  // unused words decode as HALT and carry their own address
  task automatic clear_program();
    for (int i = 0; i < RAM_WORDS; i++) prog[i] = {16'h0000, 16'(i)};
  endtask

  task automatic load_program();
    for (int i = 0; i < RAM_WORDS; i++) begin
      @(negedge clk_i);
      check_quiet();
      load_we_i    = 1'b1;
      load_addr_i  = addr_t'(i);
      load_wdata_i = prog[i];
    end
    @(negedge clk_i);
    load_we_i = 1'b0;
  endtask

  function automatic word_t model_read(addr_t a);
    if (a[15:12] == 4'h0) return model_mem[a % RAM_WORDS];
    if (a[15:12] == 4'(`MINI_MCU_PERIPH_BASE >> 12)) begin
      return a[0] ? {30'b0, model_failed, model_passed} : model_exit_reg;
    end
    return '0;
  endfunction

  task automatic model_write(addr_t a, word_t d);
    if (a[15:12] == 4'h0) begin
      model_mem[a % RAM_WORDS] = d;
    end else if (a[15:12] == 4'(`MINI_MCU_PERIPH_BASE >> 12)) begin
      if (a[0]) begin
        model_passed = model_passed | d[0];
        model_failed = model_failed | d[1];
      end else begin
        model_exit_reg = d;
        model_exits.push_back(d);
      end
    end
  endtask

  // instruction level reference of the accumulator machine
  task automatic run_model();
    addr_t pc;
    word_t acc;
    word_t ins;
    addr_t opnd;
    logic  done;
    int    steps;
    pc    = '0;
    acc   = '0;
    done  = 1'b0;
    steps = 0;
    model_exits.delete();
    model_exit_reg = '0;
    model_passed   = 1'b0;
    model_failed   = 1'b0;
    for (int i = 0; i < RAM_WORDS; i++) model_mem[i] = prog[i];
    while (!done && steps < MAX_STEPS) begin
      ins  = model_read(pc);
      opnd = ins[15:0];
      steps++;
      case (ins[31:28])
        LDI: acc = word_t'(opnd);
        LD:  acc = model_read(opnd);
        ST:  model_write(opnd, acc);
        ADD: acc = acc + model_read(opnd);
        SUB: acc = acc - model_read(opnd);
        default: ;
      endcase
      if (ins[31:28] == BNZ) pc = (acc != 0) ? opnd : pc + 16'd1;
      else if (ins[31:28] == JMP) pc = opnd;
      else if (ins[31:28] inside {LDI, LD, ST, ADD, SUB}) pc = pc + 16'd1;
      else done = 1'b1;
    end
    if (!done) begin
      $display("reference model did not halt within %0d steps", MAX_STEPS);
      errors++;
    end
  endtask

  task automatic run_program();
    int   cyc;
    logic slept;
    dut_exits.delete();
    slept = 1'b0;
    cyc   = 0;
    @(negedge clk_i);
    fetch_enable_i = 1'b1;
    while (!slept && cyc < RUN_CYCLES) begin
      @(negedge clk_i);
      cyc++;
      if (exit_valid_o) dut_exits.push_back(exit_value_o);
      if (core_sleep_o) slept = 1'b1;
    end
    if (!slept) begin
      $display("core did not reach sleep within %0d cycles", RUN_CYCLES);
      errors++;
    end
    // keep watching after the halt for stray exit writes
    repeat (SETTLE_CYCLES) begin
      @(negedge clk_i);
      if (exit_valid_o) dut_exits.push_back(exit_value_o);
      if (slept && !core_sleep_o) begin
        $display("core left sleep at %0t after halting", $time);
        errors++;
      end
    end
    fetch_enable_i = 1'b0;
  endtask

  task automatic compare_results();
    int n;
    if (dut_exits.size() != model_exits.size()) begin
      $display("expected %0d exit pulses but saw %0d", model_exits.size(), dut_exits.size());
      errors++;
    end
    n = (dut_exits.size() < model_exits.size()) ? dut_exits.size() : model_exits.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("exit_value_o[%0d]", i), model_exits[i], dut_exits[i]);
    end
    check_word("tests_passed_o", word_t'(model_passed), word_t'(tests_passed_o));
    check_word("tests_failed_o", word_t'(model_failed), word_t'(tests_failed_o));
    check_word("core_sleep_o", 32'd1, word_t'(core_sleep_o));
    for (int i = 0; i < RAM_WORDS; i++) begin
      check_word($sformatf("mem[%0d]", i), model_mem[i], dut0.ram0.mem[i]);
    end
  endtask

  task automatic execute_and_check();
    load_program();
    run_model();
    run_program();
    compare_results();
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (dut0.chk0.fail_count != assert_fails) begin
      $display("%0d protocol assertions failed during test %s",
               dut0.chk0.fail_count - assert_fails, name);
      errors       += dut0.chk0.fail_count - assert_fails;
      assert_fails  = dut0.chk0.fail_count;
    end
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_errors);
      tests_bad++;
    end
    test_errors = errors;
  endtask

  task automatic test_idle();
    reset_dut();
    clear_program();
    prog[0] = encode_instr(LDI, 16'h0003);
    prog[1] = encode_instr(ST, STATUS_ADDR);
    prog[2] = encode_instr(ST, EXIT_ADDR);
    load_program();
    repeat (100) begin
      @(negedge clk_i);
      check_quiet();
    end
    finish_test("idle");
  endtask

  task automatic test_arith();
    reset_dut();
    clear_program();
    prog[0] = encode_instr(LDI, 16'($urandom));
    prog[1] = encode_instr(ADD, 16'h0080);
    prog[2] = encode_instr(SUB, 16'h0081);
    prog[3] = encode_instr(ADD, 16'h0082);
    prog[4] = encode_instr(ST, EXIT_ADDR);
    prog[5] = encode_instr(HALT, 16'h0000);
    for (int i = 0; i < 3; i++) prog[8'h80 + i] = $urandom;
    execute_and_check();
    finish_test("arith");
  endtask

  // the ADD at word 1 walks through the data as the loop rewrites its operand
  task automatic test_loop();
    int n;
    n = 1 + ($urandom % 8);
    reset_dut();
    clear_program();
    prog[0]  = encode_instr(LD, 16'h00f0);
    prog[1]  = encode_instr(ADD, 16'h00a0);
    prog[2]  = encode_instr(ST, 16'h00f0);
    prog[3]  = encode_instr(ST, EXIT_ADDR);
    prog[4]  = encode_instr(LD, 16'h0001);
    prog[5]  = encode_instr(ADD, 16'h00f2);
    prog[6]  = encode_instr(ST, 16'h0001);
    prog[7]  = encode_instr(LD, 16'h00f1);
    prog[8]  = encode_instr(SUB, 16'h00f2);
    prog[9]  = encode_instr(ST, 16'h00f1);
    prog[10] = encode_instr(BNZ, 16'h0000);
    prog[11] = encode_instr(HALT, 16'h0000);
    prog[8'hf0] = '0;
    prog[8'hf1] = word_t'(n);
    prog[8'hf2] = 32'd1;
    for (int i = 0; i < n; i++) prog[8'ha0 + i] = $urandom;
    execute_and_check();
    finish_test("loop");
  endtask

  task automatic test_mem_roundtrip();
    reset_dut();
    clear_program();
    prog[0]  = encode_instr(LD, 16'h00c0);
    prog[1]  = encode_instr(ST, 16'h0090);
    prog[2]  = encode_instr(LDI, 16'h0000);
    prog[3]  = encode_instr(LD, 16'h0090);
    prog[4]  = encode_instr(ST, EXIT_ADDR);
    prog[5]  = encode_instr(LDI, 16'h0055);
    prog[6]  = encode_instr(ST, UNMAPPED_ADDR);
    prog[7]  = encode_instr(LD, UNMAPPED_ADDR);
    prog[8]  = encode_instr(ST, EXIT_ADDR);
    prog[9]  = encode_instr(HALT, 16'h0000);
    prog[8'hc0] = $urandom;
    execute_and_check();
    finish_test("mem_roundtrip");
  endtask

  task automatic test_verdict();
    reset_dut();
    clear_program();
    prog[0]  = encode_instr(LDI, 16'h0001);
    prog[1]  = encode_instr(ST, STATUS_ADDR);
    prog[2]  = encode_instr(LD, STATUS_ADDR);
    prog[3]  = encode_instr(ST, EXIT_ADDR);
    prog[4]  = encode_instr(LDI, 16'h0000);
    prog[5]  = encode_instr(ST, STATUS_ADDR);
    prog[6]  = encode_instr(LD, STATUS_ADDR);
    prog[7]  = encode_instr(ST, EXIT_ADDR);
    prog[8]  = encode_instr(LDI, 16'h0002);
    prog[9]  = encode_instr(ST, STATUS_ADDR);
    prog[10] = encode_instr(LDI, 16'h0000);
    prog[11] = encode_instr(ST, STATUS_ADDR);
    prog[12] = encode_instr(LD, STATUS_ADDR);
    prog[13] = encode_instr(ST, EXIT_ADDR);
    prog[14] = encode_instr(HALT, 16'h0000);
    execute_and_check();
    finish_test("verdict");
  endtask

  // HALT first, then an undefined opcode in the same slot
  task automatic test_halt();
    logic [3:0] stop_op [2];
    stop_op[0] = HALT;
    stop_op[1] = 4'hc;
    for (int k = 0; k < 2; k++) begin
      reset_dut();
      clear_program();
      prog[0] = encode_instr(LDI, 16'h0007);
      prog[1] = encode_instr(ST, EXIT_ADDR);
      prog[2] = encode_instr(stop_op[k], 16'h0000);
      prog[3] = encode_instr(LDI, 16'h0009);
      prog[4] = encode_instr(ST, EXIT_ADDR);
      prog[5] = encode_instr(LDI, 16'h0002);
      prog[6] = encode_instr(ST, STATUS_ADDR);
      execute_and_check();
    end
    finish_test("halt");
  endtask

  initial begin
    errors         = 0;
    test_errors    = 0;
    assert_fails   = 0;
    tests_run      = 0;
    tests_bad      = 0;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    load_we_i      = 1'b0;
    load_addr_i    = '0;
    load_wdata_i   = '0;
    seed_val       = $urandom(32'hcd303d7e);
    test_idle();
    test_arith();
    test_loop();
    test_mem_roundtrip();
    test_verdict();
    test_halt();
    $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, tests_bad,
             errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tiny_core.sv */
`timescale 1ns/100ps

module tiny_core (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     fetch_enable_i,
  input  mini_mcu_pkg::bus_resp_t  bus_resp_i,
  output mini_mcu_pkg::bus_req_t   bus_req_o,
  output logic                     core_sleep_o
);

  import mini_mcu_pkg::*;

  core_state_e state_q;
  core_state_e state_d;
  addr_t       pc_q;
  addr_t       pc_d;
  word_t       acc_q;
  word_t       acc_d;
  word_t       instr_q;
  opcode_e     op;
  addr_t       operand;
  logic        mem_op;

  // decode straight from the latched instruction word
  assign op      = opcode_e'(instr_q[31:28]);
  assign operand = instr_q[$bits(addr_t)-1:0];
  assign mem_op  = op inside {LD, ST, ADD, SUB};

  // request fields come from registers only, so they hold until gnt
  always_comb begin
    bus_req_o = '0;
    case (state_q)
      FETCH: begin
        bus_req_o.req  = 1'b1;
        bus_req_o.addr = pc_q;
      end
      EXECUTE: begin
        if (mem_op) begin
          bus_req_o.req   = 1'b1;
          bus_req_o.we    = (op == ST);
          bus_req_o.addr  = operand;
          bus_req_o.wdata = acc_q;
        end
      end
      default: begin
        bus_req_o = '0;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    acc_d   = acc_q;
    case (state_q)
      IDLE: begin
        if (fetch_enable_i) state_d = FETCH;
      end
      FETCH: begin
        if (bus_resp_i.gnt) state_d = WAIT_INSTR;
      end
      WAIT_INSTR: begin
        if (bus_resp_i.rvalid) state_d = EXECUTE;
      end
      EXECUTE: begin
        case (op)
          LDI: begin
            acc_d   = word_t'(operand);
            pc_d    = pc_q + addr_t'(1);
            state_d = FETCH;
          end
          LD, ST, ADD, SUB: begin
            if (bus_resp_i.gnt) state_d = WAIT_DATA;
          end
          BNZ: begin
            pc_d    = (acc_q != '0) ? operand : pc_q + addr_t'(1);
            state_d = FETCH;
          end
          JMP: begin
            pc_d    = operand;
            state_d = FETCH;
          end
          // HALT and every undefined code stop the core
          default: state_d = SLEEP;
        endcase
      end
      WAIT_DATA: begin
        if (bus_resp_i.rvalid) begin
          case (op)
            LD:      acc_d = bus_resp_i.rdata;
            ADD:     acc_d = acc_q + bus_resp_i.rdata;
            SUB:     acc_d = acc_q - bus_resp_i.rdata;
            default: acc_d = acc_q;
          endcase
          pc_d    = pc_q + addr_t'(1);
          state_d = FETCH;
        end
      end
      // sleep is left only through reset
      SLEEP:   state_d = SLEEP;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      pc_q    <= '0;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_INSTR && bus_resp_i.rvalid) begin
      instr_q <= bus_resp_i.rdata;
    end
  end

  assign core_sleep_o = (state_q == SLEEP);

endmodule
